// ==== verilog/dir_defs.svh ====
`ifndef DIR_DEFS_SVH
`define DIR_DEFS_SVH

// Directory sizing
`define DIR_LINES       16
`define DIR_AGENTS      4 // Sharer bitmap and destination mask width

// Queue depths
`define REQ_FIFO_DEPTH  4
`define MSG_FIFO_DEPTH  8

// Wishbone word addresses
`define ADR_REQ         2'd0
`define ADR_MSG         2'd1
`define ADR_STATUS      2'd2

`endif

// ==== verilog/dir_pkg.sv ====
`default_nettype none
`include "dir_defs.svh"

package dir_pkg;

	localparam int LINE_W  = $clog2(`DIR_LINES);
	localparam int AGENT_W = $clog2(`DIR_AGENTS);

	typedef logic [LINE_W-1:0]      dir_line_t;
	typedef logic [AGENT_W-1:0]     dir_agent_t;
	typedef logic [`DIR_AGENTS-1:0] dir_mask_t; // One bit per cache

	// Stable states only
	typedef enum logic [1:0] {
		STATE_I = 2'd0,
		STATE_S = 2'd1,
		STATE_M = 2'd2
	} dir_state_t;

	typedef logic [3:0] dir_msg_t;

	// Requests from caches
	localparam dir_msg_t MSG_GETS     = 4'd1;
	localparam dir_msg_t MSG_GETM     = 4'd2;
	localparam dir_msg_t MSG_PUTS     = 4'd3;
	localparam dir_msg_t MSG_PUTM     = 4'd4;
	// Messages from the directory
	localparam dir_msg_t MSG_DATA     = 4'd5;
	localparam dir_msg_t MSG_PUTACK   = 4'd6;
	localparam dir_msg_t MSG_INV      = 4'd7;
	localparam dir_msg_t MSG_FWD_GETS = 4'd8;
	localparam dir_msg_t MSG_FWD_GETM = 4'd9;

	// Host request, taken from wb_wdata[9:0]
	typedef struct packed {
		dir_msg_t   msg;
		dir_agent_t requestor;
		dir_line_t  line;
	} dir_req_t;

	// Outgoing message, returned in wb_rdata[11:0]
	typedef struct packed {
		dir_msg_t  msg;
		dir_mask_t dest;
		dir_line_t line;
	} dir_out_t;

	typedef struct packed {
		dir_state_t state;
		dir_agent_t owner;
		dir_mask_t  sharers;
	} dir_entry_t;

	typedef struct packed {
		// Response
		logic       resp_send;
		dir_msg_t   resp_type;
		logic       resp_to_requestor;
		logic       resp_to_owner;
		// Forward
		logic       fwd_send;
		dir_msg_t   fwd_type;
		logic       fwd_to_owner;
		logic       fwd_to_sharers;
		// Entry updates
		logic       sharers_add_requestor;
		logic       sharers_add_owner;
		logic       sharers_remove_requestor;
		logic       sharers_clear;
		logic       owner_set_requestor;
		logic       owner_clear;
		dir_state_t next_state;
		logic       admitted;
	} dir_action_t;

endpackage

`default_nettype wire

// ==== verilog/msg_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module msg_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = 4
) (
	input  wire logic                   clk,
	input  wire logic                   arst_n,
	input  wire logic                   push,
	input  wire payload_t               push_data,
	input  wire logic                   pop,
	output payload_t                    pop_data,
	output logic                        empty,
	output logic                        full,
	output logic [$clog2(DEPTH+1)-1:0]  level
);

	localparam int PTR_W = $clog2(DEPTH);
	localparam int LVL_W = $clog2(DEPTH + 1);

	payload_t         mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic             do_push;
	logic             do_pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign empty    = (level == '0);
	assign full     = (level == LVL_W'(DEPTH));
	assign do_push  = push & ~full; // Push into a full buffer is lost
	assign do_pop   = pop & ~empty;
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({do_push, do_pop})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: level <= level; // Both or neither
			endcase
		end
	end

	// Storage
	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

endmodule

`default_nettype wire

// ==== verilog/wb_dir_port.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dir_defs.svh"

module wb_dir_port import dir_pkg::*; (
	input  wire logic        clk,
	input  wire logic        arst_n,
	// Wishbone classic slave
	input  wire logic        wb_cyc,
	input  wire logic        wb_stb,
	input  wire logic        wb_we,
	input  wire logic [1:0]  wb_adr,
	input  wire logic [15:0] wb_wdata,
	output logic      [15:0] wb_rdata,
	output logic             wb_ack,
	// Request FIFO
	output logic             req_push,
	output dir_req_t         req_data,
	input  wire logic        req_full,
	// Message FIFO
	output logic             msg_pop,
	input  wire dir_out_t    msg_data,
	input  wire logic        msg_empty,
	input  wire logic [7:0]  err_count
);

	logic        access; // Cycle seen, ack on the next edge
	logic        wr_req;
	logic        rd_msg;
	logic        overflow;
	logic [15:0] rdata_d;

	// ---------------------------------------------------------------------
	// Bus decode
	// ---------------------------------------------------------------------
	assign access = wb_cyc & wb_stb & ~wb_ack; // Gap cycle after every ack
	assign wr_req = access & wb_we & (wb_adr == `ADR_REQ);
	assign rd_msg = access & ~wb_we & (wb_adr == `ADR_MSG);

	assign req_data = dir_req_t'(wb_wdata[$bits(dir_req_t)-1:0]);
	assign req_push = wr_req & ~req_full;
	assign msg_pop  = rd_msg & ~msg_empty;

	// ---------------------------------------------------------------------
	// Read data
	// ---------------------------------------------------------------------
	always_comb begin
		rdata_d = '0;
		case (wb_adr)
			`ADR_MSG: begin
				if (!msg_empty) begin
					rdata_d[$bits(dir_out_t)-1:0] = msg_data;
					rdata_d[15]                   = 1'b1; // Valid
				end
			end
			`ADR_STATUS: begin
				rdata_d[7:0] = err_count;
				rdata_d[8]   = overflow;
			end
			default: rdata_d = '0;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_ack   <= 1'b0;
			overflow <= 1'b0;
		end else begin
			wb_ack <= access;
			// Dropped request, sticky until reset
			if (wr_req && req_full)
				overflow <= 1'b1;
		end
	end

	// Captured with the pop so data and ack line up
	always_ff @(posedge clk) begin
		if (access && !wb_we)
			wb_rdata <= rdata_d;
	end

endmodule

`default_nettype wire

// ==== verilog/dir_protocol_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module dir_protocol_table import dir_pkg::*; (
	input  wire dir_state_t state,
	input  wire dir_msg_t   request,
	input  wire logic       from_owner,
	input  wire logic       one_sharer,
	output dir_action_t     action
);

	always_comb begin
		action            = '0;
		action.next_state = state; // Stay unless a rule moves the line

		case (state)
			// -------------------------------------------------------------
			// State I
			// -------------------------------------------------------------
			STATE_I: begin
				case (request)
					MSG_GETS: begin
						action.resp_send             = 1'b1;
						action.resp_type             = MSG_DATA;
						action.resp_to_requestor     = 1'b1;
						action.sharers_add_requestor = 1'b1;
						action.next_state            = STATE_S;
						action.admitted              = 1'b1;
					end
					MSG_GETM: begin
						action.resp_send           = 1'b1;
						action.resp_type           = MSG_DATA;
						action.resp_to_requestor   = 1'b1;
						action.owner_set_requestor = 1'b1;
						action.next_state          = STATE_M;
						action.admitted            = 1'b1;
					end
					MSG_PUTS, MSG_PUTM: begin // Nothing held, just ack
						action.resp_send         = 1'b1;
						action.resp_type         = MSG_PUTACK;
						action.resp_to_requestor = 1'b1;
						action.admitted          = 1'b1;
					end
					default: ;
				endcase
			end

			// -------------------------------------------------------------
			// State S
			// -------------------------------------------------------------
			STATE_S: begin
				case (request)
					MSG_GETS: begin
						action.resp_send             = 1'b1;
						action.resp_type             = MSG_DATA;
						action.resp_to_requestor     = 1'b1;
						action.sharers_add_requestor = 1'b1;
						action.admitted              = 1'b1;
					end
					MSG_GETM: begin
						action.resp_send           = 1'b1;
						action.resp_type           = MSG_DATA;
						action.resp_to_requestor   = 1'b1;
						action.fwd_send            = 1'b1; // Inv to the other sharers
						action.fwd_type            = MSG_INV;
						action.fwd_to_sharers      = 1'b1;
						action.sharers_clear       = 1'b1;
						action.owner_set_requestor = 1'b1;
						action.next_state          = STATE_M;
						action.admitted            = 1'b1;
					end
					MSG_PUTS: begin
						action.sharers_remove_requestor = 1'b1;
						action.resp_send                = 1'b1;
						action.resp_type                = MSG_PUTACK;
						action.resp_to_requestor        = 1'b1;
						action.admitted                 = 1'b1;
						if (one_sharer)
							action.next_state = STATE_I; // Last sharer gone
					end
					MSG_PUTM: begin
						// PutM from an owner has no meaning here
						if (!from_owner) begin
							action.sharers_remove_requestor = 1'b1;
							action.resp_send                = 1'b1;
							action.resp_type                = MSG_PUTACK;
							action.resp_to_requestor        = 1'b1;
							action.admitted                 = 1'b1;
						end
					end
					default: ;
				endcase
			end

			// -------------------------------------------------------------
			// State M
			// -------------------------------------------------------------
			STATE_M: begin
				case (request)
					MSG_GETS: begin
						action.fwd_send              = 1'b1;
						action.fwd_type              = MSG_FWD_GETS;
						action.fwd_to_owner          = 1'b1;
						action.sharers_add_requestor = 1'b1;
						action.sharers_add_owner     = 1'b1;
						action.owner_clear           = 1'b1;
						action.next_state            = STATE_S; // No S_D wait
						action.admitted              = 1'b1;
					end
					MSG_GETM: begin
						action.fwd_send            = 1'b1;
						action.fwd_type            = MSG_FWD_GETM;
						action.fwd_to_owner        = 1'b1;
						action.owner_set_requestor = 1'b1;
						action.admitted            = 1'b1;
					end
					MSG_PUTS, MSG_PUTM: begin
						action.resp_send         = 1'b1;
						action.resp_type         = MSG_PUTACK;
						action.resp_to_requestor = 1'b1;
						action.admitted          = 1'b1;
						if (request == MSG_PUTM && from_owner) begin
							action.owner_clear = 1'b1;
							action.next_state  = STATE_I;
						end
					end
					default: ;
				endcase
			end

			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/dir_engine.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dir_defs.svh"

module dir_engine import dir_pkg::*; (
	input  wire logic                                  clk,
	input  wire logic                                  arst_n,
	// Request FIFO
	input  wire logic                                  req_empty,
	output logic                                       req_pop,
	input  wire dir_req_t                              req_data,
	// Message FIFO
	input  wire logic [$clog2(`MSG_FIFO_DEPTH+1)-1:0]  msg_level,
	output logic                                       msg_push,
	output dir_out_t                                   msg_data,
	output logic [7:0]                                 err_count
);

	localparam int LVL_W = $clog2(`MSG_FIFO_DEPTH + 1);

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_APPLY,
		SEQ_FWD
	} seq_t;

	seq_t        seq;
	dir_entry_t  dir_mem [`DIR_LINES];
	dir_entry_t  cur;
	dir_entry_t  upd;
	dir_action_t action;
	dir_mask_t   req_bit;
	dir_mask_t   owner_bit;
	logic        from_owner;
	logic        one_sharer;
	logic        room;
	dir_out_t    resp_msg;
	dir_out_t    fwd_next;
	dir_out_t    fwd_msg;
	logic        fwd_pend;

	// ---------------------------------------------------------------------
	// Lookup and table
	// ---------------------------------------------------------------------
	assign cur        = dir_mem[req_data.line];
	assign req_bit    = dir_mask_t'(1) << req_data.requestor;
	assign owner_bit  = dir_mask_t'(1) << cur.owner;
	assign from_owner = (cur.state == STATE_M) && (cur.owner == req_data.requestor);
	assign one_sharer = (cur.sharers == req_bit);
	assign room       = (msg_level <= LVL_W'(`MSG_FIFO_DEPTH - 2)); // Response plus forward

	dir_protocol_table u_table (
		.state      (cur.state),
		.request    (req_data.msg),
		.from_owner (from_owner),
		.one_sharer (one_sharer),
		.action     (action)
	);

	always_comb begin
		upd = cur;
		if (action.sharers_clear)
			upd.sharers = '0;
		if (action.sharers_add_requestor)
			upd.sharers = upd.sharers | req_bit;
		if (action.sharers_add_owner)
			upd.sharers = upd.sharers | owner_bit;
		if (action.sharers_remove_requestor)
			upd.sharers = upd.sharers & ~req_bit;
		if (action.owner_set_requestor)
			upd.owner = req_data.requestor;
		if (action.owner_clear)
			upd.owner = '0;
		upd.state = action.next_state;
	end

	// Destinations come from the entry before the update
	always_comb begin
		resp_msg.msg  = action.resp_type;
		resp_msg.dest = (action.resp_to_requestor ? req_bit : '0) |
		                (action.resp_to_owner ? owner_bit : '0);
		resp_msg.line = req_data.line;

		fwd_next.msg  = action.fwd_type;
		fwd_next.dest = (action.fwd_to_owner ? owner_bit : '0) |
		                (action.fwd_to_sharers ? (cur.sharers & ~req_bit) : '0);
		fwd_next.line = req_data.line;
	end

	// ---------------------------------------------------------------------
	// Sequencer
	// ---------------------------------------------------------------------
	assign req_pop  = (seq == SEQ_APPLY);
	assign msg_push = ((seq == SEQ_APPLY) && action.resp_send) ||
	                  ((seq == SEQ_FWD) && fwd_pend);
	assign msg_data = (seq == SEQ_FWD) ? fwd_msg : resp_msg;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			seq       <= SEQ_IDLE;
			fwd_pend  <= 1'b0;
			err_count <= '0;
			for (int i = 0; i < `DIR_LINES; i++)
				dir_mem[i] <= '0; // State I, no owner, no sharers
		end else begin
			case (seq)
				SEQ_IDLE: begin
					if (!req_empty && room)
						seq <= SEQ_APPLY;
				end
				SEQ_APPLY: begin
					if (action.admitted)
						dir_mem[req_data.line] <= upd;
					else
						err_count <= err_count + 1'b1;
					fwd_pend <= action.fwd_send;
					seq      <= SEQ_FWD;
				end
				SEQ_FWD: begin
					fwd_pend <= 1'b0;
					seq      <= SEQ_IDLE;
				end
				default: seq <= SEQ_IDLE;
			endcase
		end
	end

	// Forward held over for the FWD cycle
	always_ff @(posedge clk) begin
		if (seq == SEQ_APPLY)
			fwd_msg <= fwd_next;
	end

endmodule

`default_nettype wire

// ==== verilog/dir_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dir_defs.svh"

module dir_ctrl_top import dir_pkg::*; (
	input  wire logic        clk,
	input  wire logic        arst_n,
	input  wire logic        wb_cyc,
	input  wire logic        wb_stb,
	input  wire logic        wb_we,
	input  wire logic [1:0]  wb_adr,
	input  wire logic [15:0] wb_wdata,
	output logic      [15:0] wb_rdata,
	output logic             wb_ack
);

	// Request path
	dir_req_t   req_wdata;
	dir_req_t   req_rdata;
	logic       req_push;
	logic       req_pop;
	logic       req_full;
	logic       req_empty;

	// Message path
	dir_out_t   msg_wdata;
	dir_out_t   msg_rdata;
	logic       msg_push;
	logic       msg_pop;
	logic       msg_empty;
	logic [$clog2(`MSG_FIFO_DEPTH+1)-1:0] msg_level;

	logic [7:0] err_count;

	wb_dir_port u_wb_port (
		.clk       (clk),
		.arst_n    (arst_n),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_wdata  (wb_wdata),
		.wb_rdata  (wb_rdata),
		.wb_ack    (wb_ack),
		.req_push  (req_push),
		.req_data  (req_wdata),
		.req_full  (req_full),
		.msg_pop   (msg_pop),
		.msg_data  (msg_rdata),
		.msg_empty (msg_empty),
		.err_count (err_count)
	);

	msg_fifo #(.payload_t(dir_req_t), .DEPTH(`REQ_FIFO_DEPTH)) u_req_fifo (
		.clk       (clk),
		.arst_n    (arst_n),
		.push      (req_push),
		.push_data (req_wdata),
		.pop       (req_pop),
		.pop_data  (req_rdata),
		.empty     (req_empty),
		.full      (req_full),
		.level     ()
	);

	msg_fifo #(.payload_t(dir_out_t), .DEPTH(`MSG_FIFO_DEPTH)) u_msg_fifo (
		.clk       (clk),
		.arst_n    (arst_n),
		.push      (msg_push),
		.push_data (msg_wdata),
		.pop       (msg_pop),
		.pop_data  (msg_rdata),
		.empty     (msg_empty),
		.full      (),
		.level     (msg_level) // Engine checks room from this
	);

	dir_engine u_engine (
		.clk       (clk),
		.arst_n    (arst_n),
		.req_empty (req_empty),
		.req_pop   (req_pop),
		.req_data  (req_rdata),
		.msg_level (msg_level),
		.msg_push  (msg_push),
		.msg_data  (msg_wdata),
		.err_count (err_count)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_dir_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dir_defs.svh"

module tb_dir_ctrl import dir_pkg::*; ();

	localparam int CLK_PERIOD      = 100;
	localparam int WATCHDOG_CYCLES = 2000; // Under 100 bus accesses of 3 cycles with wide margin
	localparam int ACK_LIMIT       = 16;
	localparam int POLL_LIMIT      = 24;   // Reads before a message counts as missing
	localparam int IDLE_READS      = 4;    // Empty reads that end the final drain
	localparam int RAND_WRITES     = 20;
	localparam int LINE_A          = 3;
	localparam int LINE_B          = 5;
	localparam int LINE_C          = 6;

	logic        clk;
	logic        arst_n;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [1:0]  wb_adr;
	logic [15:0] wb_wdata;
	logic [15:0] wb_rdata;
	logic        wb_ack;

	// Reference directory and predicted messages
	dir_state_t  ref_state   [`DIR_LINES];
	dir_agent_t  ref_owner   [`DIR_LINES];
	dir_mask_t   ref_sharers [`DIR_LINES];
	dir_out_t    exp_q [$];
	int          ref_errs; // Requests the rules do not admit

	int          errors;
	int          checks;
	int          tests_failed;
	int          errs_before;
	integer      seed;

	dir_ctrl_top u_dir_ctrl_top (
		.clk      (clk),
		.arst_n   (arst_n),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_wdata (wb_wdata),
		.wb_rdata (wb_rdata),
		.wb_ack   (wb_ack)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, run did not complete", WATCHDOG_CYCLES);
		$display("TESTBENCH FAILED");
		$finish;
	end

	// -------------------------------------------------------------------
	// Bus access and message checks
	// -------------------------------------------------------------------
	task automatic bus_access(input logic we, input logic [1:0] adr, input logic [15:0] wdata,
			output logic [15:0] rdata);
		int waited;
		waited = 0;
		@(posedge clk);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= we;
		wb_adr   <= adr;
		wb_wdata <= wdata;
		@(negedge clk);
		while (!wb_ack && waited < ACK_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (!wb_ack) begin
			$display("Bus access to address %0d was never acked (at %0d ns)", adr, $time);
			errors++;
		end
		rdata = wb_rdata; // Stable in the low half of the clock
		@(posedge clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	function automatic string fmt_msg(input dir_out_t m);
		return $sformatf("msg %0d dest %b line %0d", m.msg, m.dest, m.line);
	endfunction

	function automatic void expect_msg(input dir_msg_t code, input dir_mask_t dest,
			input dir_line_t line);
		dir_out_t m;
		m.msg  = code;
		m.dest = dest;
		m.line = line;
		exp_q.push_back(m);
	endfunction

	// Directory rules for the stable states
	function automatic void apply_rules(input dir_req_t r);
		dir_mask_t me;
		dir_mask_t own_bit;
		logic      last;
		me      = dir_mask_t'(1) << r.requestor;
		own_bit = dir_mask_t'(1) << ref_owner[r.line];
		case (ref_state[r.line])
			STATE_I: begin
				case (r.msg)
					MSG_GETS: begin
						expect_msg(MSG_DATA, me, r.line);
						ref_sharers[r.line] = ref_sharers[r.line] | me;
						ref_state[r.line]   = STATE_S;
					end
					MSG_GETM: begin
						expect_msg(MSG_DATA, me, r.line);
						ref_owner[r.line] = r.requestor;
						ref_state[r.line] = STATE_M;
					end
					MSG_PUTS, MSG_PUTM: expect_msg(MSG_PUTACK, me, r.line);
					default: ref_errs++; // Not admitted and the line is untouched
				endcase
			end
			STATE_S: begin
				case (r.msg)
					MSG_GETS: begin
						expect_msg(MSG_DATA, me, r.line);
						ref_sharers[r.line] = ref_sharers[r.line] | me;
					end
					MSG_GETM: begin
						expect_msg(MSG_DATA, me, r.line);
						expect_msg(MSG_INV, ref_sharers[r.line] & ~me, r.line);
						ref_sharers[r.line] = '0;
						ref_owner[r.line]   = r.requestor;
						ref_state[r.line]   = STATE_M;
					end
					MSG_PUTS, MSG_PUTM: begin // No owner while shared
						last = (ref_sharers[r.line] == me);
						ref_sharers[r.line] = ref_sharers[r.line] & ~me;
						expect_msg(MSG_PUTACK, me, r.line);
						if (r.msg == MSG_PUTS && last)
							ref_state[r.line] = STATE_I;
					end
					default: ref_errs++;
				endcase
			end
			STATE_M: begin
				case (r.msg)
					MSG_GETS: begin
						expect_msg(MSG_FWD_GETS, own_bit, r.line);
						ref_sharers[r.line] = ref_sharers[r.line] | me | own_bit;
						ref_owner[r.line]   = '0;
						ref_state[r.line]   = STATE_S;
					end
					MSG_GETM: begin
						expect_msg(MSG_FWD_GETM, own_bit, r.line);
						ref_owner[r.line] = r.requestor;
					end
					MSG_PUTS, MSG_PUTM: begin
						expect_msg(MSG_PUTACK, me, r.line);
						if (r.msg == MSG_PUTM && ref_owner[r.line] == r.requestor) begin
							ref_owner[r.line] = '0;
							ref_state[r.line] = STATE_I;
						end
					end
					default: ref_errs++;
				endcase
			end
			default: ;
		endcase
	endfunction

	task automatic send_req(input int line, input int agent, input dir_msg_t code);
		dir_req_t    r;
		logic [15:0] wdata;
		logic [15:0] unused_rd;
		r.msg       = code;
		r.requestor = dir_agent_t'(agent);
		r.line      = dir_line_t'(line);
		wdata       = '0;
		wdata[$bits(dir_req_t)-1:0] = r;
		bus_access(1'b1, `ADR_REQ, wdata, unused_rd);
		apply_rules(r);
	endtask

	// Reads every predicted message in order, then one more that must be empty
	task automatic check_msgs();
		dir_out_t    want;
		dir_out_t    got;
		logic [15:0] rd;
		int          polls;
		while (exp_q.size() > 0) begin
			want  = exp_q.pop_front();
			polls = 0;
			do begin
				bus_access(1'b0, `ADR_MSG, 16'h0, rd);
				polls++;
			end while (!rd[15] && polls < POLL_LIMIT);
			got = rd[$bits(dir_out_t)-1:0];
			checks++;
			if (!rd[15]) begin
				$display("Message %s never became readable (at %0d ns)", fmt_msg(want), $time);
				errors++;
			end else begin
				assert (got == want)
				else begin
					$display("[FAIL] %0d ns: expected %s, got %s", $time, fmt_msg(want),
						fmt_msg(got));
					errors++;
				end
			end
		end
		bus_access(1'b0, `ADR_MSG, 16'h0, rd);
		got = rd[$bits(dir_out_t)-1:0];
		checks++;
		assert (!rd[15])
		else begin
			$display("[FAIL] %0d ns: expected no message, got %s", $time, fmt_msg(got));
			errors++;
		end
	endtask

	task automatic report_test(input int num, input string name);
		if (errors == errs_before) begin
			$display("Test %0d %s: ok", num, name);
		end else begin
			$display("Test %0d %s: %0d error(s)", num, name, errors - errs_before);
			tests_failed++;
		end
		errs_before = errors;
	endtask

	// -------------------------------------------------------------------
	// Stimulus
	// -------------------------------------------------------------------
	initial begin
		logic [15:0] rd;
		logic [15:0] wdata;
		logic [31:0] rnd;
		dir_line_t   w_line  [RAND_WRITES];
		dir_agent_t  w_agent [RAND_WRITES];
		dir_out_t    got;
		dir_req_t    r;
		int          polls;
		int          idle;
		int          ptr;
		int          drained;
		logic        found;

		arst_n   = 1'b0;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = 2'd0;
		wb_wdata = 16'h0;
		errors       = 0;
		checks       = 0;
		tests_failed = 0;
		errs_before  = 0;
		ref_errs     = 0;
		for (int i = 0; i < `DIR_LINES; i++) begin
			ref_state[i]   = STATE_I;
			ref_owner[i]   = '0;
			ref_sharers[i] = '0;
		end
		repeat (5) @(posedge clk);
		arst_n <= 1'b1;

		send_req(LINE_A, 0, MSG_GETS);
		send_req(LINE_A, 1, MSG_GETS);
		check_msgs();
		report_test(1, "GetS on an I line");

		send_req(LINE_A, 2, MSG_GETM);
		check_msgs();
		report_test(2, "GetM on an S line");

		send_req(LINE_A, 3, MSG_GETS);
		check_msgs();
		send_req(LINE_A, 0, MSG_GETM);
		check_msgs();
		report_test(3, "GetS then GetM on an M line");

		send_req(LINE_A, 0, MSG_PUTM); // Owner gives up and the line goes to I
		check_msgs();
		send_req(LINE_A, 1, MSG_GETS);
		check_msgs();
		send_req(LINE_B, 2, MSG_GETM);
		check_msgs();
		send_req(LINE_B, 1, MSG_PUTM); // Not the owner
		check_msgs();
		send_req(LINE_B, 3, MSG_GETS); // Still M with owner 2
		check_msgs();
		send_req(LINE_A, 1, MSG_PUTS); // Last sharer
		check_msgs();
		send_req(LINE_A, 3, MSG_GETM);
		check_msgs();
		report_test(4, "PutM and PutS");

		send_req(LINE_C, 1, dir_msg_t'(0));
		send_req(LINE_C, 2, dir_msg_t'(12));
		polls = 0;
		do begin
			bus_access(1'b0, `ADR_STATUS, 16'h0, rd);
			polls++;
		end while (rd[7:0] != 8'(ref_errs) && polls < POLL_LIMIT);
		checks++;
		assert (rd[7:0] == 8'(ref_errs))
		else begin
			$display("[FAIL] %0d ns: expected error count %0d, got %0d", $time, ref_errs,
				rd[7:0]);
			errors++;
		end
		check_msgs();
		report_test(5, "Codes not admitted");

		// Lines 8 to 15 are still I or S, so every GetS answers with Data
		seed = 32'h896c;
		for (int i = 0; i < RAND_WRITES; i++) begin
			rnd         = $random(seed);
			w_line[i]   = {1'b1, rnd[2:0]};
			w_agent[i]  = rnd[5:4];
			r.msg       = MSG_GETS;
			r.requestor = w_agent[i];
			r.line      = w_line[i];
			wdata       = '0;
			wdata[$bits(dir_req_t)-1:0] = r;
			bus_access(1'b1, `ADR_REQ, wdata, rd);
		end
		bus_access(1'b0, `ADR_STATUS, 16'h0, rd);
		checks++;
		assert (rd[8])
		else begin
			$display("[FAIL] %0d ns: expected overflow bit 1, got 0", $time);
			errors++;
		end
		idle    = 0;
		ptr     = 0;
		drained = 0;
		while (idle < IDLE_READS) begin
			bus_access(1'b0, `ADR_MSG, 16'h0, rd);
			if (!rd[15]) begin
				idle++;
			end else begin
				idle = 0;
				drained++;
				got   = rd[$bits(dir_out_t)-1:0];
				found = 1'b0;
				// Dropped writes are skipped but the order must hold
				while (ptr < RAND_WRITES && !found) begin
					if (w_line[ptr] == got.line && (dir_mask_t'(1) << w_agent[ptr]) == got.dest)
						found = 1'b1;
					ptr++;
				end
				checks++;
				assert (got.msg == MSG_DATA && found)
				else begin
					$display("[FAIL] %0d ns: expected Data for a later write, got %s", $time,
						fmt_msg(got));
					errors++;
				end
			end
		end
		checks++;
		assert (drained <= `MSG_FIFO_DEPTH + `REQ_FIFO_DEPTH)
		else begin
			$display("[FAIL] %0d ns: expected at most %0d messages, got %0d", $time,
				`MSG_FIFO_DEPTH + `REQ_FIFO_DEPTH, drained);
			errors++;
		end
		report_test(6, "Random GetS with overflow");

		$display("Tests: 6 run, %0d failed; checks: %0d; errors: %0d", tests_failed, checks,
			errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+verilog
verilog/dir_pkg.sv
verilog/msg_fifo.sv
verilog/wb_dir_port.sv
verilog/dir_protocol_table.sv
verilog/dir_engine.sv
verilog/dir_ctrl_top.sv
testbench/tb_dir_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the directory controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_dir_ctrl \
	-o sim_dir_ctrl > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sim_dir_ctrl > sim.log 2>&1
cat sim.log

grep -q "TESTBENCH PASSED" sim.log && exit 0 || exit 1
